/* hw/vision_pkg.sv */
`default_nettype none

package vision_pkg;

    // ========================================
    // raster geometry
    // ========================================
    // scaled-down raster, keeps simulation short
    localparam int H_ACTIVE    = 32;
    localparam int H_TOTAL     = 40;
    localparam int V_ACTIVE    = 24;
    localparam int V_TOTAL     = 28;
    // vsync low on lines 25 and 26
    localparam int VSYNC_START = 25;
    localparam int VSYNC_END   = 27;
    // counter widths
    localparam int H_CNT_W     = $clog2(H_TOTAL);
    localparam int V_CNT_W     = $clog2(V_TOTAL);

    // ========================================
    // frame memory split
    // ========================================
    localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;
    localparam int ADDR_W       = 10;
    // bank 0 holds 0..511, bank 1 the rest at addr - 512
    localparam int BANK0_DEPTH  = 512;
    localparam int BANK1_DEPTH  = FRAME_PIXELS - BANK0_DEPTH;
    localparam int BANK0_AW     = $clog2(BANK0_DEPTH);
    localparam int BANK1_AW     = $clog2(BANK1_DEPTH);

    // pipeline latencies, counted from the raster address
    localparam int MEM_RD_LAT   = 2;
    localparam int PROC_LAT     = 2;
    // plus one display output register
    localparam int PIPE_LATENCY = MEM_RD_LAT + PROC_LAT + 1;

    // gray weights, sum is 256
    localparam logic [7:0] GRAY_W_R = 8'd77;
    localparam logic [7:0] GRAY_W_G = 8'd150;
    localparam logic [7:0] GRAY_W_B = 8'd29;

    // foreground when |gray - bg| is strictly above this
    localparam logic [7:0] BG_THRESHOLD = 8'd40;

    // display modes, code 3 falls back to original colour
    typedef enum logic [1:0] {
        MODE_ORIG   = 2'd0,
        MODE_GRAY   = 2'd1,
        MODE_BG_SUB = 2'd2
    } display_mode_e;

    // rgb565 -> rgb888, low bits padded with ones
    function automatic logic [23:0] expand_rgb565(input logic [15:0] pix);
        return {pix[15:11], 3'b111, pix[10:5], 2'b11, pix[4:0], 3'b111};
    endfunction

endpackage

`default_nettype wire

/* hw/raster_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_scan import vision_pkg::*; (
    input  logic              clk_25MHz,
    input  logic              rst,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              active,
    output logic              vsync,
    output logic              vga_enable
);

    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;
    logic               h_last;
    logic               v_last;
    logic               pos_active;
    logic               pos_vsync;
    logic               frame_start;
    logic               vsync_prev;

    // position decode from the current counters
    assign h_last      = (h_cnt == H_CNT_W'(H_TOTAL - 1));
    assign v_last      = (v_cnt == V_CNT_W'(V_TOTAL - 1));
    assign pos_active  = (h_cnt < H_CNT_W'(H_ACTIVE)) && (v_cnt < V_CNT_W'(V_ACTIVE));
    assign pos_vsync   = (v_cnt >= V_CNT_W'(VSYNC_START)) && (v_cnt < V_CNT_W'(VSYNC_END));
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

    // ========================================
    // pixel and line counters
    // ========================================
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            // wrap to line 0 after the last blank line
            v_cnt <= v_last ? '0 : v_cnt + V_CNT_W'(1);
        end else begin
            h_cnt <= h_cnt + H_CNT_W'(1);
        end
    end

    // registered timing outputs, one pixel per cycle
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            active  <= 1'b0;
            vsync   <= 1'b1;
            rd_addr <= '0;
        end else begin
            active <= pos_active;
            vsync  <= !pos_vsync;
            // address holds through blanking, restarts each frame
            if (pos_active) begin
                rd_addr <= frame_start ? '0 : rd_addr + ADDR_W'(1);
            end
        end
    end

    // display enable latches on first vsync rising edge
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            vsync_prev <= 1'b1;
            vga_enable <= 1'b0;
        end else begin
            vsync_prev <= vsync;
            if (vsync && !vsync_prev) begin
                vga_enable <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/frame_store.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_store import vision_pkg::*; (
    input  logic              clk_25MHz,
    input  logic              wren,
    input  logic [ADDR_W-1:0] wraddress,
    input  logic [15:0]       wrdata,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [15:0]       rd_data
);

    // two rgb565 banks
    logic [15:0] bank0 [BANK0_DEPTH];
    logic [15:0] bank1 [BANK1_DEPTH];

    logic [ADDR_W-1:0]   wr_off1;
    logic [ADDR_W-1:0]   rd_off1;
    logic                wr_hi;
    logic                rd_hi;
    logic [BANK0_AW-1:0] rd_addr0_q;
    logic [BANK1_AW-1:0] rd_addr1_q;
    logic                bank_d1;
    logic                bank_d2;
    logic [15:0]         q0;
    logic [15:0]         q1;

    // ========================================
    // write side
    // ========================================
    // bank 1 addressed relative to its base
    assign wr_hi   = (wraddress >= ADDR_W'(BANK0_DEPTH));
    assign wr_off1 = wraddress - ADDR_W'(BANK0_DEPTH);

    always_ff @(posedge clk_25MHz) begin
        if (wren && !wr_hi) begin
            bank0[wraddress[BANK0_AW-1:0]] <= wrdata;
        end
        if (wren && wr_hi) begin
            bank1[wr_off1[BANK1_AW-1:0]] <= wrdata;
        end
    end

    // ========================================
    // read side
    // ========================================
    assign rd_hi   = (rd_addr >= ADDR_W'(BANK0_DEPTH));
    assign rd_off1 = rd_addr - ADDR_W'(BANK0_DEPTH);

    // stage 1 registers the bank addresses
    // stage 2 registers the ram outputs
    always_ff @(posedge clk_25MHz) begin
        rd_addr0_q <= rd_addr[BANK0_AW-1:0];
        rd_addr1_q <= rd_off1[BANK1_AW-1:0];
        bank_d1    <= rd_hi;
        q0         <= bank0[rd_addr0_q];
        q1         <= bank1[rd_addr1_q];
        // bank bit follows the data
        bank_d2    <= bank_d1;
    end

    // output mux, data valid at T0+2
    assign rd_data = bank_d2 ? q1 : q0;

endmodule

`default_nettype wire

/* hw/pixel_process.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_process import vision_pkg::*; (
    input  logic              clk_25MHz,
    input  logic              rst,
    input  logic [ADDR_W-1:0] rd_addr,
    input  logic              active,
    input  logic              vga_enable,
    input  logic [15:0]       rd_data,
    output logic [15:0]       pix_rgb565,
    output logic [7:0]        pix_gray,
    output logic              pix_fg,
    output logic              pix_active
);

    localparam int ACT_W = MEM_RD_LAT + PROC_LAT;

    // addr_dly[0] is T0+1, addr_dly[MEM_RD_LAT] is T0+3
    logic [ADDR_W-1:0] addr_dly [MEM_RD_LAT+1];
    // act_sr[i] is the active flag at T0+1+i
    logic [ACT_W-1:0]  act_sr;

    logic [23:0]       rgb888;
    logic [15:0]       gray_sum;
    logic [7:0]        gray_q;
    logic [15:0]       pix_q;
    logic [7:0]        bg_mem [FRAME_PIXELS];
    logic [7:0]        bg_q;
    logic [7:0]        gray_diff;
    logic              bg_load;
    logic              fg_hit;

    // ========================================
    // alignment with memory latency
    // ========================================
    always_ff @(posedge clk_25MHz) begin
        addr_dly[0] <= rd_addr;
        for (int i = 1; i <= MEM_RD_LAT; i++) begin
            addr_dly[i] <= addr_dly[i-1];
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            act_sr <= '0;
        end else begin
            act_sr <= {act_sr[ACT_W-2:0], active};
        end
    end

    // ========================================
    // gray conversion, registered at T0+3
    // ========================================
    assign rgb888   = expand_rgb565(rd_data);
    // weights sum to 256, top byte is the gray value
    assign gray_sum = {8'd0, rgb888[23:16]} * {8'd0, GRAY_W_R}
                    + {8'd0, rgb888[15:8]}  * {8'd0, GRAY_W_G}
                    + {8'd0, rgb888[7:0]}   * {8'd0, GRAY_W_B};

    always_ff @(posedge clk_25MHz) begin
        gray_q <= gray_sum[15:8];
        pix_q  <= rd_data;
    end

    // ========================================
    // background buffer
    // ========================================
    // first frame after reset fills the buffer
    assign bg_load = !vga_enable && act_sr[MEM_RD_LAT];

    always_ff @(posedge clk_25MHz) begin
        // read at T0+2, data ready T0+3
        bg_q <= bg_mem[addr_dly[MEM_RD_LAT-1]];
        // write at T0+3 with matching address
        if (bg_load) begin
            bg_mem[addr_dly[MEM_RD_LAT]] <= gray_q;
        end
    end

    // absolute difference live vs background
    assign gray_diff = (gray_q >= bg_q) ? (gray_q - bg_q) : (bg_q - gray_q);
    // compare only once the buffer is loaded
    assign fg_hit    = vga_enable && act_sr[MEM_RD_LAT] && (gray_diff > BG_THRESHOLD);

    // outputs aligned at T0+4
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            pix_fg <= 1'b0;
        end else begin
            pix_fg <= fg_hit;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        pix_gray   <= gray_q;
        pix_rgb565 <= pix_q;
    end

    assign pix_active = act_sr[ACT_W-1];

endmodule

`default_nettype wire

/* hw/display_select.sv */
`timescale 1ns/1ps
`default_nettype none

module display_select import vision_pkg::*; (
    input  logic          clk_25MHz,
    input  logic          rst,
    input  display_mode_e display_mode,
    input  logic [15:0]   pix_rgb565,
    input  logic [7:0]    pix_gray,
    input  logic          pix_fg,
    input  logic          pix_active,
    output logic          pixel_valid,
    output logic [7:0]    display_r,
    output logic [7:0]    display_g,
    output logic [7:0]    display_b,
    output logic          fg_mask
);

    logic [23:0] rgb888;
    logic [7:0]  sel_r;
    logic [7:0]  sel_g;
    logic [7:0]  sel_b;

    assign rgb888 = expand_rgb565(pix_rgb565);

    // ========================================
    // mode mux
    // ========================================
    always_comb begin
        // original colour unless a mode overrides
        sel_r = rgb888[23:16];
        sel_g = rgb888[15:8];
        sel_b = rgb888[7:0];
        case (display_mode)
            MODE_GRAY: begin
                sel_r = pix_gray;
                sel_g = pix_gray;
                sel_b = pix_gray;
            end
            MODE_BG_SUB: begin
                // background pixels go black
                if (!pix_fg) begin
                    sel_r = 8'd0;
                    sel_g = 8'd0;
                    sel_b = 8'd0;
                end
            end
            default: begin
            end
        endcase
    end

    // registered outputs at T0+5, blanked outside active area
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            pixel_valid <= 1'b0;
            display_r   <= 8'd0;
            display_g   <= 8'd0;
            display_b   <= 8'd0;
            fg_mask     <= 1'b0;
        end else begin
            pixel_valid <= pix_active;
            display_r   <= pix_active ? sel_r : 8'd0;
            display_g   <= pix_active ? sel_g : 8'd0;
            display_b   <= pix_active ? sel_b : 8'd0;
            fg_mask     <= pix_active && pix_fg;
        end
    end

endmodule

`default_nettype wire

/* hw/cam_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_display_top import vision_pkg::*; (
    input  logic              clk_25MHz,
    input  logic              rst,
    input  logic              wren,
    input  logic [ADDR_W-1:0] wraddress,
    input  logic [15:0]       wrdata,
    input  display_mode_e     display_mode,
    output logic              vga_enable,
    output logic              vsync,
    output logic              pixel_valid,
    output logic [7:0]        display_r,
    output logic [7:0]        display_g,
    output logic [7:0]        display_b,
    output logic              fg_mask
);

    // scanner to store and processor
    logic [ADDR_W-1:0] rd_addr;
    logic              active;
    // store to processor
    logic [15:0]       rd_data;
    // processor to selector, aligned at T0+4
    logic [15:0]       pix_rgb565;
    logic [7:0]        pix_gray;
    logic              pix_fg;
    logic              pix_active;

    // ========================================
    // timing
    // ========================================
    raster_scan u_raster_scan (
        .clk_25MHz  (clk_25MHz),
        .rst        (rst),
        .rd_addr    (rd_addr),
        .active     (active),
        .vsync      (vsync),
        .vga_enable (vga_enable)
    );

    // frame buffer, written by external source
    frame_store u_frame_store (
        .clk_25MHz (clk_25MHz),
        .wren      (wren),
        .wraddress (wraddress),
        .wrdata    (wrdata),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // gray and background subtraction
    pixel_process u_pixel_process (
        .clk_25MHz  (clk_25MHz),
        .rst        (rst),
        .rd_addr    (rd_addr),
        .active     (active),
        .vga_enable (vga_enable),
        .rd_data    (rd_data),
        .pix_rgb565 (pix_rgb565),
        .pix_gray   (pix_gray),
        .pix_fg     (pix_fg),
        .pix_active (pix_active)
    );

    // output mux and blanking
    display_select u_display_select (
        .clk_25MHz    (clk_25MHz),
        .rst          (rst),
        .display_mode (display_mode),
        .pix_rgb565   (pix_rgb565),
        .pix_gray     (pix_gray),
        .pix_fg       (pix_fg),
        .pix_active   (pix_active),
        .pixel_valid  (pixel_valid),
        .display_r    (display_r),
        .display_g    (display_g),
        .display_b    (display_b),
        .fg_mask      (fg_mask)
    );

endmodule

`default_nettype wire

/* verif/cam_display_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_display_sva import vision_pkg::*; (
    input wire logic              clk_25MHz,
    input wire logic              rst,
    input wire logic              wren,
    input wire logic [ADDR_W-1:0] wraddress,
    input wire logic              vga_enable,
    input wire logic              pixel_valid,
    input wire logic [7:0]        display_r,
    input wire logic [7:0]        display_g,
    input wire logic [7:0]        display_b,
    input wire logic              fg_mask
);

    // enable is a one-way latch
    a_enable_holds: assert property (@(posedge clk_25MHz) disable iff (rst)
        vga_enable |=> vga_enable)
        else $error("vga_enable fell after rising");

    // blanking outside the active area
    a_blank_outputs: assert property (@(posedge clk_25MHz) disable iff (rst)
        !pixel_valid |-> (display_r == 8'd0 && display_g == 8'd0
                          && display_b == 8'd0 && !fg_mask))
        else $error("colour or mask nonzero while pixel_valid is low");

    // writer stays inside the frame
    a_write_range: assert property (@(posedge clk_25MHz)
        wren |-> (wraddress < ADDR_W'(FRAME_PIXELS)))
        else $error("write address beyond the frame");

endmodule

bind cam_display_top cam_display_sva u_sva (.*);

`default_nettype wire

/* verif/tb_cam_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cam_display import vision_pkg::*; ();

    localparam int          RESET_CYCLES   = 16;
    localparam int          FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    // 12 frames plus reset
    localparam int          TIMEOUT_CYCLES = 12 * FRAME_CYCLES + RESET_CYCLES;
    localparam int          VSYNC_LOW_CYC  = (VSYNC_END - VSYNC_START) * H_TOTAL;
    localparam logic [31:0] SEED           = 32'h0afa_2c04;

    logic              clk_25MHz;
    logic              rst;
    logic              wren;
    logic [ADDR_W-1:0] wraddress;
    logic [15:0]       wrdata;
    display_mode_e     display_mode;
    logic              vga_enable;
    logic              vsync;
    logic              pixel_valid;
    logic [7:0]        display_r;
    logic [7:0]        display_g;
    logic [7:0]        display_b;
    logic              fg_mask;

    // shadow of frame memory and background
    logic [15:0]   img [FRAME_PIXELS];
    logic [15:0]   img_a [FRAME_PIXELS];
    logic [7:0]    bg_gray [FRAME_PIXELS];
    display_mode_e mode_exp;
    logic          check_on;
    int            errors;
    int            checks;
    int            tests;
    int            cycle;
    int            checked_pix;

    cam_display_top dut (
        .clk_25MHz    (clk_25MHz),
        .rst          (rst),
        .wren         (wren),
        .wraddress    (wraddress),
        .wrdata       (wrdata),
        .display_mode (display_mode),
        .vga_enable   (vga_enable),
        .vsync        (vsync),
        .pixel_valid  (pixel_valid),
        .display_r    (display_r),
        .display_g    (display_g),
        .display_b    (display_b),
        .fg_mask      (fg_mask)
    );

    always #20 clk_25MHz = !clk_25MHz;

    // ========================================
    // reference model
    // ========================================
    function automatic logic [23:0] expand_colour(input logic [15:0] w);
        return {w[15:11], 3'b111, w[10:5], 2'b11, w[4:0], 3'b111};
    endfunction

    function automatic logic [7:0] gray_of(input logic [15:0] w);
        logic [23:0] c;
        int          s;
        c = expand_colour(w);
        s = int'(GRAY_W_R) * int'(c[23:16]) + int'(GRAY_W_G) * int'(c[15:8])
          + int'(GRAY_W_B) * int'(c[7:0]);
        return 8'(s >> 8);
    endfunction

    // {fg, r, g, b} for one stored word
    function automatic logic [24:0] expected_pixel(input logic [15:0] w,
                                                   input logic [7:0] bg,
                                                   input display_mode_e mode);
        logic [23:0] c;
        logic [7:0]  g;
        int          diff;
        logic        fg;
        c    = expand_colour(w);
        g    = gray_of(w);
        diff = int'(g) - int'(bg);
        if (diff < 0) begin
            diff = -diff;
        end
        fg = (diff > int'(BG_THRESHOLD));
        case (mode)
            MODE_GRAY:   return {fg, g, g, g};
            MODE_BG_SUB: return fg ? {1'b1, c} : 25'd0;
            default:     return {fg, c};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_start);
    endtask

    task automatic write_word(input int addr, input logic [15:0] data);
        @(posedge clk_25MHz);
        wren      <= 1'b1;
        wraddress <= ADDR_W'(addr);
        wrdata    <= data;
        img[addr]  = data;
    endtask

    task automatic write_done();
        @(posedge clk_25MHz);
        wren <= 1'b0;
    endtask

    // opens a compared frame at the next vsync fall
    task automatic start_checked_frame(input display_mode_e mode);
        @(negedge vsync);
        @(posedge clk_25MHz);
        display_mode <= mode;
        mode_exp     = mode;
        checked_pix  = 0;
        check_on     = 1'b1;
    endtask

    // closes it at the following vsync fall
    task automatic finish_checked_frame();
        @(negedge vsync);
        check_on = 1'b0;
        check_value("checked_pixels", 32'(checked_pix), 32'(FRAME_PIXELS));
    endtask

    // one frame compared in the given mode
    task automatic run_checked_frame(input display_mode_e mode);
        start_checked_frame(mode);
        finish_checked_frame();
    endtask

    // ========================================
    // comparing process, samples on falling edge
    // ========================================
    logic        vsync_prev;
    logic        rise_seen;
    int          valid_cnt;
    int          low_cnt;
    logic [24:0] exp_pix;

    always @(negedge clk_25MHz) begin
        if (rst) begin
            vsync_prev = 1'b1;
            rise_seen  = 1'b0;
            valid_cnt  = 0;
            low_cnt    = 0;
        end else begin
            // enable may not rise before vsync has gone low and back
            if (vga_enable && !rise_seen) begin
                errors++;
                $display("vga_enable rose before the first vsync low period ended");
            end
            if (vsync_prev && !vsync) begin
                check_value("valid_per_frame", 32'(valid_cnt), 32'(FRAME_PIXELS));
                valid_cnt = 0;
            end
            if (!vsync) begin
                low_cnt++;
            end else if (!vsync_prev) begin
                check_value("vsync_low_cycles", 32'(low_cnt), 32'(VSYNC_LOW_CYC));
                low_cnt   = 0;
                rise_seen = 1'b1;
            end
            vsync_prev = vsync;
            if (pixel_valid) begin
                if (valid_cnt >= FRAME_PIXELS) begin
                    errors++;
                    $display("more valid pixels in a frame than the frame holds");
                end else if (check_on) begin
                    exp_pix = expected_pixel(img[valid_cnt], bg_gray[valid_cnt], mode_exp);
                    check_value("fg_mask", 32'(fg_mask), 32'(exp_pix[24]));
                    check_value("display_r", 32'(display_r), 32'(exp_pix[23:16]));
                    check_value("display_g", 32'(display_g), 32'(exp_pix[15:8]));
                    check_value("display_b", 32'(display_b), 32'(exp_pix[7:0]));
                    checked_pix++;
                end
                valid_cnt++;
            end
        end
    end

    // timeout
    always @(posedge clk_25MHz) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // reset sequence with checks of reset values
    initial begin
        repeat (RESET_CYCLES - 1) @(posedge clk_25MHz);
        @(negedge clk_25MHz);
        check_value("vga_enable", 32'(vga_enable), 32'h0);
        check_value("pixel_valid", 32'(pixel_valid), 32'h0);
        check_value("fg_mask", 32'(fg_mask), 32'h0);
        check_value("vsync", 32'(vsync), 32'h1);
        @(posedge clk_25MHz);
        rst <= 1'b0;
    end

    // ========================================
    // test sequence
    // ========================================
    initial begin
        int          err_start;
        logic [15:0] w;
        clk_25MHz    = 1'b0;
        rst          = 1'b1;
        wren         = 1'b0;
        wraddress    = '0;
        wrdata       = '0;
        display_mode = MODE_ORIG;
        mode_exp     = MODE_ORIG;
        check_on     = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        cycle        = 0;
        checked_pix  = 0;
        void'($urandom(SEED));
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            img_a[i]   = 16'($urandom);
            bg_gray[i] = gray_of(img_a[i]);
        end

        // image A, each word lands ahead of its first-frame read
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            write_word(i, img_a[i]);
        end
        write_done();

        err_start = 0;
        while (!vga_enable) begin
            @(posedge clk_25MHz);
        end
        report_test("reset values", err_start);

        err_start = errors;
        repeat (2) @(negedge vsync);
        report_test("frame geometry", err_start);

        err_start = errors;
        run_checked_frame(MODE_ORIG);
        report_test("original mode", err_start);

        err_start = errors;
        run_checked_frame(MODE_GRAY);
        report_test("gray mode", err_start);

        // image B, even pixels far from A in gray, odd pixels close
        err_start = errors;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            if (i % 2 == 0) begin
                w = (bg_gray[i] < 8'd128) ? 16'hffff : 16'h0000;
            end else begin
                w = img_a[i] ^ 16'h0001;
            end
            write_word(i, w);
        end
        write_done();
        run_checked_frame(MODE_BG_SUB);
        report_test("background subtraction", err_start);

        // single pixels in both banks, written in blanking, visible next frame
        err_start = errors;
        start_checked_frame(MODE_ORIG);
        write_word(3, ~img[3]);
        write_word(BANK0_DEPTH - 1, ~img[BANK0_DEPTH - 1]);
        write_word(BANK0_DEPTH, ~img[BANK0_DEPTH]);
        write_word(FRAME_PIXELS - 1, ~img[FRAME_PIXELS - 1]);
        write_done();
        finish_checked_frame();
        report_test("live writes", err_start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hw/vision_pkg.sv
hw/raster_scan.sv
hw/frame_store.sv
hw/pixel_process.sv
hw/display_select.sv
hw/cam_display_top.sv
verif/cam_display_sva.sv
verif/tb_cam_display.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_cam_display
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
